// File: include/gomoku_params.svh
`ifndef GOMOKU_PARAMS_SVH
`define GOMOKU_PARAMS_SVH

// Board geometry of the game.
`define BOARD_SIZE 15

// Stones in one line that win the game.
`define WIN_LEN 5

// Cells on the board, and also the move count that ends in a draw.
`define NUM_CELLS 225

// Width of a row or a column index.
`define COORD_W 4

`endif

// File: src/gomoku_pkg.sv
`default_nettype none

package gomoku_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Contents of one board cell, also used for the player to move.
    typedef enum logic [1:0] {
        CELL_BLACK = 2'd0,
        CELL_WHITE = 2'd1,
        CELL_EMPTY = 2'd2
    } cell_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // States of the move controller.
    typedef enum logic [1:0] {
        ST_PLAY  = 2'd0, // Waiting for a move.
        ST_CHECK = 2'd1, // Stone placed, line check pending.
        ST_OVER  = 2'd2  // Win or draw reached.
    } ctrl_state_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reasons a move is rejected.
    typedef enum logic [1:0] {
        ERR_NONE     = 2'd0,
        ERR_RANGE    = 2'd1,
        ERR_OCCUPIED = 2'd2,
        ERR_OVER     = 2'd3
    } move_err_t;

endpackage

`default_nettype wire

// File: src/board_store.sv
`default_nettype none

`include "gomoku_params.svh"

module board_store import gomoku_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        clear,
    input  logic                        wr_en,
    input  logic [`COORD_W-1:0]         wr_row,
    input  logic [`COORD_W-1:0]         wr_col,
    input  cell_t                       wr_cell,
    output cell_t [`NUM_CELLS-1:0]      board,
    output cell_t                       cur_cell,
    input  logic [`COORD_W-1:0]         peek_row,
    input  logic [`COORD_W-1:0]         peek_col,
    output cell_t                       peek_cell
);

    localparam int IDX_W = $clog2(`NUM_CELLS);

    cell_t [`NUM_CELLS-1:0] board_q;
    logic  [IDX_W-1:0]      wr_idx;
    logic  [IDX_W-1:0]      peek_idx;
    logic                   wr_inside;
    logic                   peek_inside;

    // Cell (row, col) sits at row * 15 + col.
    assign wr_idx   = IDX_W'(wr_row) * IDX_W'(`BOARD_SIZE) + IDX_W'(wr_col);
    assign peek_idx = IDX_W'(peek_row) * IDX_W'(`BOARD_SIZE) + IDX_W'(peek_col);

    assign wr_inside   = (wr_row < `BOARD_SIZE) && (wr_col < `BOARD_SIZE);
    assign peek_inside = (peek_row < `BOARD_SIZE) && (peek_col < `BOARD_SIZE);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cell registers.
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            for (int i = 0; i < `NUM_CELLS; i++) begin
                board_q[i] <= CELL_EMPTY;
            end
        end else if (wr_en) begin
            board_q[wr_idx] <= wr_cell;
        end
    end

    assign board = board_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read ports. Off-board coordinates read as empty.
    assign cur_cell  = wr_inside ? board_q[wr_idx] : CELL_EMPTY;
    assign peek_cell = peek_inside ? board_q[peek_idx] : CELL_EMPTY;

    // The controller only writes empty cells on the board.
    a_write_empty : assert property (
        @(posedge clk) disable iff (rst)
        (wr_en && !clear) |-> (wr_inside && cur_cell == CELL_EMPTY)
    ) else $error("board_store: write to an occupied or off-board cell");

endmodule

`default_nettype wire

// File: src/check_five.sv
`default_nettype none

`include "gomoku_params.svh"

module check_five import gomoku_pkg::*; (
    input  cell_t [`NUM_CELLS-1:0] board,
    input  cell_t                  check_colour,
    output logic                   five_found
);

    logic [`NUM_CELLS-1:0] mine;
    logic                  hit_row;
    logic                  hit_col;
    logic                  hit_diag;
    logic                  hit_anti;

    // True when WIN_LEN cells from (r, c) along (dr, dc) all belong to the colour.
    function automatic logic line_at(
        input logic [`NUM_CELLS-1:0] m,
        input int                    r,
        input int                    c,
        input int                    dr,
        input int                    dc
    );
        logic all_set;
        all_set = 1'b1;
        for (int k = 0; k < `WIN_LEN; k++) begin
            all_set = all_set & m[(r + k * dr) * `BOARD_SIZE + c + k * dc];
        end
        return all_set;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One compare per cell, shared by all four scans.
    always_comb begin
        for (int i = 0; i < `NUM_CELLS; i++) begin
            mine[i] = (board[i] == check_colour);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Window scans. Each direction ORs over all of its windows.
    always_comb begin
        hit_row  = 1'b0;
        hit_col  = 1'b0;
        hit_diag = 1'b0;
        hit_anti = 1'b0;

        for (int r = 0; r < `BOARD_SIZE; r++) begin
            for (int c = 0; c <= `BOARD_SIZE - `WIN_LEN; c++) begin
                hit_row = hit_row | line_at(mine, r, c, 0, 1);
            end
        end

        for (int r = 0; r <= `BOARD_SIZE - `WIN_LEN; r++) begin
            for (int c = 0; c < `BOARD_SIZE; c++) begin
                hit_col = hit_col | line_at(mine, r, c, 1, 0);
            end
        end

        for (int r = 0; r <= `BOARD_SIZE - `WIN_LEN; r++) begin
            for (int c = 0; c <= `BOARD_SIZE - `WIN_LEN; c++) begin
                hit_diag = hit_diag | line_at(mine, r, c, 1, 1);
            end
        end

        // Anti-diagonal windows start at the right end and step left.
        for (int r = 0; r <= `BOARD_SIZE - `WIN_LEN; r++) begin
            for (int c = `WIN_LEN - 1; c < `BOARD_SIZE; c++) begin
                hit_anti = hit_anti | line_at(mine, r, c, 1, -1);
            end
        end
    end

    assign five_found = hit_row | hit_col | hit_diag | hit_anti;

endmodule

`default_nettype wire

// File: src/move_ctrl.sv
`default_nettype none

`include "gomoku_params.svh"

module move_ctrl import gomoku_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                new_game,
    input  logic                move_valid,
    input  logic [`COORD_W-1:0] move_row,
    input  logic [`COORD_W-1:0] move_col,
    input  cell_t               cur_cell,
    input  logic                five_found,
    output logic                wr_en,
    output logic                clear,
    output logic [`COORD_W-1:0] wr_row,
    output logic [`COORD_W-1:0] wr_col,
    output cell_t               wr_cell,
    output cell_t               check_colour,
    output cell_t               turn,
    output logic                move_done,
    output logic                move_err,
    output move_err_t           err_code,
    output logic                game_over,
    output cell_t               winner
);

    ctrl_state_t state;
    move_err_t   check_err;
    logic [7:0]  move_count; // Stones placed this game.
    logic        in_range;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Move validation. The store reads back the target cell as cur_cell.
    assign in_range = (move_row < `BOARD_SIZE) && (move_col < `BOARD_SIZE);

    always_comb begin
        if (state == ST_OVER) begin
            check_err = ERR_OVER;
        end else if (!in_range) begin
            check_err = ERR_RANGE;
        end else if (cur_cell != CELL_EMPTY) begin
            check_err = ERR_OCCUPIED;
        end else begin
            check_err = ERR_NONE;
        end
    end

    assign wr_en   = move_valid && !new_game && (state == ST_PLAY) && (check_err == ERR_NONE);
    assign clear   = new_game;
    assign wr_row  = move_row;
    assign wr_col  = move_col;
    assign wr_cell = turn;
    assign check_colour = turn; // Still the mover while in ST_CHECK.

    assign game_over = (state == ST_OVER);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Game FSM.
    always_ff @(posedge clk) begin
        if (rst || new_game) begin
            state      <= ST_PLAY;
            turn       <= CELL_BLACK;
            winner     <= CELL_EMPTY;
            move_count <= '0;
            move_done  <= 1'b0;
            move_err   <= 1'b0;
            err_code   <= ERR_NONE;
        end else begin
            move_done <= 1'b0;
            move_err  <= 1'b0;
            err_code  <= ERR_NONE;
            case (state)
                ST_PLAY, ST_OVER: begin
                    if (move_valid && check_err != ERR_NONE) begin
                        move_err <= 1'b1;
                        err_code <= check_err;
                    end else if (wr_en) begin
                        move_count <= move_count + 8'd1;
                        state      <= ST_CHECK;
                    end
                end
                ST_CHECK: begin
                    move_done <= 1'b1; // Board already holds the new stone here.
                    if (five_found) begin
                        winner <= turn;
                        state  <= ST_OVER;
                    end else if (move_count == 8'(`NUM_CELLS)) begin
                        winner <= CELL_EMPTY;
                        state  <= ST_OVER;
                    end else begin
                        turn  <= (turn == CELL_BLACK) ? CELL_WHITE : CELL_BLACK;
                        state <= ST_PLAY;
                    end
                end
                default: state <= ST_PLAY;
            endcase
        end
    end

    // No move may follow an accepted one by a single cycle.
    a_no_move_in_check : assert property (
        @(posedge clk) disable iff (rst)
        (state == ST_CHECK) |-> !move_valid
    ) else $error("move_ctrl: move arrived while the previous one was being checked");

    a_done_err_excl : assert property (
        @(posedge clk) disable iff (rst)
        !(move_done && move_err)
    ) else $error("move_ctrl: move_done and move_err high together");

endmodule

`default_nettype wire

// File: src/gomoku_top.sv
`default_nettype none

`include "gomoku_params.svh"

module gomoku_top import gomoku_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                new_game,
    input  logic                move_valid,
    input  logic [`COORD_W-1:0] move_row,
    input  logic [`COORD_W-1:0] move_col,
    input  logic [`COORD_W-1:0] peek_row,
    input  logic [`COORD_W-1:0] peek_col,
    output cell_t               peek_cell,
    output cell_t               turn,
    output logic                move_done,
    output logic                move_err,
    output move_err_t           err_code,
    output logic                game_over,
    output cell_t               winner
);

    logic                   wr_en;
    logic                   clear;
    logic [`COORD_W-1:0]    wr_row;
    logic [`COORD_W-1:0]    wr_col;
    cell_t                  wr_cell;
    cell_t [`NUM_CELLS-1:0] board;
    cell_t                  cur_cell;
    cell_t                  check_colour;
    logic                   five_found;

    board_store u_board_store (
        .clk       (clk),
        .rst       (rst),
        .clear     (clear),
        .wr_en     (wr_en),
        .wr_row    (wr_row),
        .wr_col    (wr_col),
        .wr_cell   (wr_cell),
        .board     (board),
        .cur_cell  (cur_cell),
        .peek_row  (peek_row),
        .peek_col  (peek_col),
        .peek_cell (peek_cell)
    );

    move_ctrl u_move_ctrl (
        .clk          (clk),
        .rst          (rst),
        .new_game     (new_game),
        .move_valid   (move_valid),
        .move_row     (move_row),
        .move_col     (move_col),
        .cur_cell     (cur_cell),
        .five_found   (five_found),
        .wr_en        (wr_en),
        .clear        (clear),
        .wr_row       (wr_row),
        .wr_col       (wr_col),
        .wr_cell      (wr_cell),
        .check_colour (check_colour),
        .turn         (turn),
        .move_done    (move_done),
        .move_err     (move_err),
        .err_code     (err_code),
        .game_over    (game_over),
        .winner       (winner)
    );

    check_five u_check_five (
        .board        (board),
        .check_colour (check_colour),
        .five_found   (five_found)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    // Free-running clock with a 4 ns period.
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule

`default_nettype wire

// File: tests/tb_checker.sv
`default_nettype none

`include "gomoku_params.svh"

module tb_checker import gomoku_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                new_game,
    input  logic                move_valid,
    input  logic [`COORD_W-1:0] move_row,
    input  logic [`COORD_W-1:0] move_col,
    input  logic [`COORD_W-1:0] peek_row,
    input  logic [`COORD_W-1:0] peek_col,
    input  cell_t               peek_cell,
    input  cell_t               turn,
    input  logic                move_done,
    input  logic                move_err,
    input  move_err_t           err_code,
    input  logic                game_over,
    input  cell_t               winner,
    output int                  errors
);
    timeunit 1ns;
    timeprecision 100ps;

    cell_t     model [`NUM_CELLS];
    cell_t     m_turn;
    cell_t     m_winner;
    logic      m_over;
    int        m_count;
    logic      checking; // A stone went down and its result is due next cycle.
    int        last_r;
    int        last_c;
    logic      exp_done;
    logic      exp_err;
    move_err_t exp_code;
    int        err_count = 0;

    assign errors = err_count;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference board.
    function automatic cell_t cell_at(input int r, input int c);
        if (r < 0 || r >= `BOARD_SIZE || c < 0 || c >= `BOARD_SIZE) begin
            return CELL_EMPTY;
        end
        return model[r * `BOARD_SIZE + c];
    endfunction

    // Stones of the mover's colour next to (r, c), walking along (dr, dc).
    function automatic int run_from(input int r, input int c, input int dr, input int dc);
        int n;
        n = 0;
        while (n < `WIN_LEN && cell_at(r + (n + 1) * dr, c + (n + 1) * dc) == m_turn) begin
            n++;
        end
        return n;
    endfunction

    function automatic logic line_through(input int r, input int c);
        logic hit;
        int   dr;
        int   dc;
        hit = 1'b0;
        for (int d = 0; d < 4; d++) begin
            dr = (d == 0) ? 0 : 1;
            dc = (d == 1) ? 0 : ((d == 3) ? -1 : 1); // Across, down, diagonal, anti-diagonal.
            hit = hit | ((1 + run_from(r, c, dr, dc) + run_from(r, c, -dr, -dc)) >= `WIN_LEN);
        end
        return hit;
    endfunction

    task automatic reset_model();
        for (int i = 0; i < `NUM_CELLS; i++) begin
            model[i] = CELL_EMPTY;
        end
        m_turn   = CELL_BLACK;
        m_winner = CELL_EMPTY;
        m_over   = 1'b0;
        m_count  = 0;
        checking = 1'b0;
        exp_done = 1'b0;
        exp_err  = 1'b0;
        exp_code = ERR_NONE;
    endtask

    task automatic expect_val(input string name, input logic [7:0] exp, input logic [7:0] got);
        if (got !== exp) begin
            err_count++;
            $display("Fail at time %0t: %s expected %0d, got %0d", $time, name, exp, got);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Inputs seen here are sampled by the DUT at the next rising edge.
    task automatic predict();
        exp_done = 1'b0;
        exp_err  = 1'b0;
        exp_code = ERR_NONE;
        if (new_game) begin
            reset_model();
        end else if (checking) begin
            checking = 1'b0;
            exp_done = 1'b1;
            if (line_through(last_r, last_c)) begin
                m_over   = 1'b1;
                m_winner = m_turn;
            end else if (m_count == `NUM_CELLS) begin
                m_over   = 1'b1;
                m_winner = CELL_EMPTY;
            end else begin
                m_turn = (m_turn == CELL_BLACK) ? CELL_WHITE : CELL_BLACK;
            end
        end else if (move_valid) begin
            exp_err = 1'b1;
            if (m_over) begin
                exp_code = ERR_OVER;
            end else if (move_row >= `BOARD_SIZE || move_col >= `BOARD_SIZE) begin
                exp_code = ERR_RANGE;
            end else if (cell_at(move_row, move_col) != CELL_EMPTY) begin
                exp_code = ERR_OCCUPIED;
            end else begin
                exp_err  = 1'b0;
                last_r   = move_row;
                last_c   = move_col;
                model[last_r * `BOARD_SIZE + last_c] = m_turn;
                m_count++;
                checking = 1'b1;
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            reset_model();
        end else begin
            expect_val("move_done", exp_done, move_done);
            expect_val("move_err", exp_err, move_err);
            expect_val("err_code", exp_code, err_code);
            expect_val("turn", m_turn, turn);
            expect_val("game_over", m_over, game_over);
            expect_val("winner", m_winner, winner);
            expect_val("peek_cell", cell_at(peek_row, peek_col), peek_cell);
            predict();
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_gomoku.sv
`default_nettype none

`include "gomoku_params.svh"

module tb_gomoku import gomoku_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    logic                clk;
    logic                rst;
    logic                new_game;
    logic                move_valid;
    logic [`COORD_W-1:0] move_row;
    logic [`COORD_W-1:0] move_col;
    logic [`COORD_W-1:0] peek_row;
    logic [`COORD_W-1:0] peek_col;
    cell_t               peek_cell;
    cell_t               turn;
    logic                move_done;
    logic                move_err;
    move_err_t           err_code;
    logic                game_over;
    cell_t               winner;
    int                  chk_errors;
    int                  timeouts = 0;
    int                  tests = 0;
    int                  black_q[$];
    int                  white_q[$];

    tb_clock u_clock (.*);

    gomoku_top UUT (.*);

    tb_checker u_checker (.*, .errors(chk_errors));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One move pulse, then wait for its result. Peek follows the move.
    task automatic play(input int r, input int c);
        logic got;
        @(posedge clk);
        move_valid <= 1'b1;
        move_row   <= 4'(r);
        move_col   <= 4'(c);
        peek_row   <= 4'(r);
        peek_col   <= 4'(c);
        @(posedge clk);
        move_valid <= 1'b0;
        got = 1'b0;
        for (int n = 0; n < 8 && !got; n++) begin
            @(negedge clk);
            got = move_done || move_err;
        end
        if (!got) begin
            $display("Timeout: the move at row %0d col %0d never got move_done or move_err", r, c);
            timeouts++;
        end
    endtask

    task automatic start_game(input bit with_move);
        @(posedge clk);
        new_game   <= 1'b1;
        move_valid <= with_move; // new_game must win over this move.
        move_row   <= 4'($urandom % 16);
        move_col   <= 4'($urandom % 16);
        @(posedge clk);
        new_game   <= 1'b0;
        move_valid <= 1'b0;
    endtask

    task automatic scan_board();
        for (int i = 0; i < 256; i++) begin
            @(posedge clk);
            peek_row <= 4'(i / 16);
            peek_col <= 4'(i % 16);
        end
    endtask

    // Stone number last of the line goes down last. Fillers sit apart on row 12.
    task automatic play_line(input int r0, input int c0, input int dr, input int dc,
                             input int len, input int last, input bit white_wins);
        int k;
        start_game(1'b0);
        for (int s = 0; s < len; s++) begin
            k = (s == len - 1) ? last : ((s < last) ? s : s + 1);
            if (white_wins) play(12, 2 * s);
            play(r0 + k * dr, c0 + k * dc);
            if (!white_wins) play(12, 2 * s);
        end
        play(15, 15);
        start_game(1'b0);
        scan_board();
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("Test %0d (%s) finished, %0d errors so far", tests, name, chk_errors + timeouts);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        rst        = 1'b1;
        new_game   = 1'b0;
        move_valid = 1'b0;
        move_row   = '0;
        move_col   = '0;
        peek_row   = '0;
        peek_col   = '0;
        void'($urandom(67290));
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        play(7, 7);
        play(7, 8);
        play(8, 8);
        finish_test("accepted moves");
        play(7, 7);
        play(15, 3);
        play(3, 15);
        play(8, 8);
        finish_test("rejected moves");

        play_line(0, 0, 0, 1, 5, 4, 1'b0);
        finish_test("row win at the top edge");
        play_line(10, 14, 1, 0, 5, 2, 1'b1);
        finish_test("column win for white");
        play_line(10, 10, 1, 1, 5, 0, 1'b0);
        finish_test("diagonal win in the corner");
        play_line(0, 14, 1, -1, 5, 4, 1'b0);
        finish_test("anti-diagonal win");
        play_line(7, 3, 0, 1, 6, 3, 1'b0);
        finish_test("six in a row");
        play_line(3, 5, 1, 1, 4, 3, 1'b0);
        finish_test("four is no win");

        // Colours alternate in pairs along each row, so no run grows past two.
        start_game(1'b0);
        for (int i = 0; i < `NUM_CELLS; i++) begin
            if ((((i % `BOARD_SIZE) + 2 * (i / `BOARD_SIZE)) & 2) != 0) white_q.push_back(i);
            else black_q.push_back(i);
        end
        for (int i = 0; i < black_q.size(); i++) begin
            play(black_q[i] / `BOARD_SIZE, black_q[i] % `BOARD_SIZE);
            if (i < white_q.size()) play(white_q[i] / `BOARD_SIZE, white_q[i] % `BOARD_SIZE);
        end
        play(0, 0);
        finish_test("draw");

        for (int g = 0; g < 4; g++) begin
            start_game(1'b1);
            for (int m = 0; m < 150; m++) begin
                play($urandom % 16, $urandom % 16);
            end
        end
        finish_test("random games");

        @(negedge clk);
        @(negedge clk);
        $display("Tests run: %0d, errors: %0d", tests, chk_errors + timeouts);
        if (chk_errors + timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
src/gomoku_pkg.sv
src/board_store.sv
src/check_five.sv
src/move_ctrl.sv
src/gomoku_top.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_gomoku.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_gomoku
FILELIST = sim.f
LOG      = sim.log
PASS_MSG = ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, then search $(LOG) for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
